/* rtl/coco_mem_pkg.sv */
// coco memory map package: bus widths, device select codes, rom bank numbers, fixed addresses
`default_nettype none

package coco_mem_pkg;

	// bus widths
	localparam int cpu_addr_w = 16;
	localparam int data_w     = 8;
	localparam int rom_bank_w = 13; // 8 KB per bank
	localparam int rom_addr_w = 20;
	localparam int ram_addr_w = 20;
	localparam int dl_addr_w  = 17;

	// three-bit device select coming out of the SAM
	typedef enum logic [2:0] {
		dev_ram  = 3'd0,
		dev_rom8 = 3'd1,
		dev_roma = 3'd2,
		dev_romc = 3'd3,
		dev_pia0 = 3'd4,
		dev_pia1 = 3'd5,
		dev_io   = 3'd6
	} dev_sel_t;

	// bank number inside the external rom, one bank per 8 KB image
	typedef logic [3:0] rom_bank_t;

	localparam rom_bank_t bank_roma_coco   = 4'd0;
	localparam rom_bank_t bank_rom8_coco   = 4'd1;
	localparam rom_bank_t bank_disk_coco   = 4'd2;
	localparam rom_bank_t bank_rom8_dragon = 4'd3;
	localparam rom_bank_t bank_roma_dragon = 4'd4;

	// dragon 64 keeps two 16 KB roms, split in four banks
	localparam rom_bank_t bank_rom8_d64_1  = 4'd5;
	localparam rom_bank_t bank_roma_d64_1  = 4'd6;
	localparam rom_bank_t bank_rom8_d64_2  = 4'd7;
	localparam rom_bank_t bank_roma_d64_2  = 4'd8;

	localparam rom_bank_t bank_disk_dragon = 4'd9;

	// cartridge lives in banks 14 and 15, bank lsb is cpu address bit 13
	localparam logic [2:0] cart_bank_hi = 3'b111;

	// fixed addresses and values
	localparam logic [cpu_addr_w-1:0] ram_clear_addr = 16'h0071; // reset vector flag byte
	localparam logic [3:0]            ram_cpu_prefix = 4'b1000;  // cpu ram sits above the roms
	localparam logic [dl_addr_w-1:0]  cart_min_addr  = 17'h00100;
	localparam logic [data_w-1:0]     idle_byte      = 8'hff;   // floating bus

endpackage

`default_nettype wire

/* rtl/addr_decode.sv */
// address decoder: sam device select to chip selects, rom bank mapping, cartridge presence
`timescale 1ns/1ps
`default_nettype none

module addr_decode import coco_mem_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  reset_n,
	input  wire logic [cpu_addr_w-1:0] cpu_addr,
	input  wire logic                  cpu_rw,
	input  wire logic                  clk_e,
	input  wire dev_sel_t              device_select,
	input  wire logic                  dragon,
	input  wire logic                  mem64kb,
	input  wire logic                  ddrb2,
	input  wire logic                  pia1_pb2,
	input  wire logic                  disk_cart_enabled,
	input  wire logic                  cart_remove,
	input  wire logic                  ioctl_download,
	input  wire logic                  ioctl_cart,
	input  wire logic                  ioctl_wr,
	input  wire logic [dl_addr_w-1:0]  ioctl_addr,
	output logic                       ram_cs,
	output logic                       rom_cs,
	output logic                       pia0_cs,
	output logic                       pia1_cs,
	output logic                       io_cs,
	output logic                       rom_src,     // high when a rom image drives the bus
	output logic [rom_addr_w-1:0]      ext_rom_addr,
	output logic                       ext_rom_rd
);

	logic      dragon64;
	logic      rom8_sel;
	logic      roma_sel;
	logic      romc_sel;
	logic      pia0_slot;
	logic      alt_pair;
	logic      romc_live;
	logic      cart_loaded;
	rom_bank_t bank;

	assign dragon64 = dragon & mem64kb;

	// one select per sam device code
	always_comb begin
		ram_cs    = 1'b0;
		rom8_sel  = 1'b0;
		roma_sel  = 1'b0;
		romc_sel  = 1'b0;
		pia0_slot = 1'b0;
		pia1_cs   = 1'b0;
		io_cs     = 1'b0;
		case (device_select)
			dev_ram:  ram_cs    = 1'b1;
			dev_rom8: rom8_sel  = 1'b1;
			dev_roma: roma_sel  = 1'b1;
			dev_romc: romc_sel  = 1'b1;
			dev_pia0: pia0_slot = 1'b1;
			dev_pia1: pia1_cs   = 1'b1;
			dev_io:   io_cs     = 1'b1;
			default:  ;
		endcase
	end

	// dragon 64 splits the pia0 slot, a2 high is the acia
	assign pia0_cs = pia0_slot & ~(dragon64 & cpu_addr[2]);

	// second rom pair only when ddrb2 drives pb2 low
	assign alt_pair = dragon64 & ddrb2 & ~pia1_pb2;

	assign rom_cs = rom8_sel | roma_sel | romc_sel;

	// bank number per model
	always_comb begin
		bank = bank_roma_coco;
		if (rom8_sel) begin
			if (dragon64)
				bank = alt_pair ? bank_rom8_d64_2 : bank_rom8_d64_1;
			else if (dragon)
				bank = bank_rom8_dragon;
			else
				bank = bank_rom8_coco;
		end else if (roma_sel) begin
			if (dragon64)
				bank = alt_pair ? bank_roma_d64_2 : bank_roma_d64_1;
			else if (dragon)
				bank = bank_roma_dragon;
			else
				bank = bank_roma_coco;
		end else if (romc_sel) begin
			if (cart_loaded)
				bank = {cart_bank_hi, cpu_addr[rom_bank_w]};
			else
				bank = dragon ? bank_disk_dragon : bank_disk_coco;
		end
	end

	// cartridge space is empty without a cart or disk rom
	assign romc_live = cart_loaded | disk_cart_enabled;

	// rom only drives data on read cycles
	assign rom_src = cpu_rw & (rom8_sel | roma_sel | (romc_sel & romc_live));

	assign ext_rom_addr = {{(rom_addr_w - 4 - rom_bank_w){1'b0}}, bank,
		cpu_addr[rom_bank_w-1:0]};
	assign ext_rom_rd = clk_e & rom_cs;

	// cart flag follows the last address of a cartridge download
	always_ff @(posedge clk) begin
		if (!reset_n)
			cart_loaded <= 1'b0;
		else if (ioctl_cart & ioctl_download & ~ioctl_wr)
			cart_loaded <= ioctl_addr > cart_min_addr; // tiny images count as no cart
		else if (cart_remove)
			cart_loaded <= 1'b0;
	end

endmodule

`default_nettype wire

/* rtl/dram_addr_latch.sv */
// dram address latch: rebuilds the sam address from ras/cas strobes and captures video bytes
`timescale 1ns/1ps
`default_nettype none

module dram_addr_latch import coco_mem_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  reset_n,
	input  wire logic                  ras_n,
	input  wire logic                  cas_n,
	input  wire logic [7:0]            ma_addr,  // multiplexed row/column address
	input  wire logic [data_w-1:0]     ram_din,
	output logic [cpu_addr_w-1:0]      sam_addr,
	output logic [data_w-1:0]          vdg_data,
	output logic                       ram_rd_cycle
);

	logic ras_n_r;
	logic cas_n_r;
	logic ras_fall;
	logic ras_rise;
	logic cas_fall;

	assign ras_fall = ~ras_n & ras_n_r;
	assign ras_rise = ras_n & ~ras_n_r;
	assign cas_fall = ~cas_n & cas_n_r;

	// strobe history, idle high
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ras_n_r      <= 1'b1;
			cas_n_r      <= 1'b1;
			ram_rd_cycle <= 1'b0;
		end else begin
			ras_n_r      <= ras_n;
			cas_n_r      <= cas_n;
			ram_rd_cycle <= ~cas_n; // cas low means a ram access is under way
		end
	end

	// row on ras, column on cas
	always_ff @(posedge clk) begin
		if (ras_fall)
			sam_addr[7:0] <= ma_addr;
		if (cas_fall)
			sam_addr[15:8] <= ma_addr;
	end

	// video fetch is complete once ras goes back high
	always_ff @(posedge clk) begin
		if (ras_rise)
			vdg_data <= ram_din;
	end

endmodule

`default_nettype wire

/* rtl/ext_mem_mux.sv */
// external memory mux: download write stretch, ram address/data/strobe muxing, cpu read data
`timescale 1ns/1ps
`default_nettype none

module ext_mem_mux import coco_mem_pkg::*; #(
	parameter int DL_STRETCH = 8
) (
	input  wire logic                  clk,
	input  wire logic                  reset_n,
	input  wire logic                  ioctl_download,
	input  wire logic                  ioctl_rom,
	input  wire logic                  ioctl_wr,
	input  wire logic [dl_addr_w-1:0]  ioctl_addr,
	input  wire logic [data_w-1:0]     ioctl_data,
	input  wire logic                  hard_reset,
	input  wire logic                  clk_e,
	input  wire logic                  cpu_rw,
	input  wire logic [data_w-1:0]     cpu_dout,
	input  wire logic [cpu_addr_w-1:0] sam_addr,
	input  wire logic                  ram_rd_cycle,
	input  wire logic                  ram_cs,
	input  wire logic                  rom_cs,
	input  wire logic                  pia0_cs,
	input  wire logic                  pia1_cs,
	input  wire logic                  io_cs,
	input  wire logic                  rom_src,
	input  wire logic [data_w-1:0]     ram_din,
	input  wire logic [data_w-1:0]     rom_din,
	input  wire logic [data_w-1:0]     pia0_dout,
	input  wire logic [data_w-1:0]     pia1_dout,
	input  wire logic [data_w-1:0]     io_dout,
	output logic [ram_addr_w-1:0]      ext_ram_addr,
	output logic [data_w-1:0]          ext_ram_dout,
	output logic                       ext_ram_wr,
	output logic                       ext_ram_rd,
	output logic [data_w-1:0]          cpu_din
);

	logic [DL_STRETCH-1:0] dl_wr;
	logic [dl_addr_w-1:0]  dl_addr;
	logic                  cpu_we;

	// each download byte holds the write strobe for DL_STRETCH clocks
	always_ff @(posedge clk) begin
		if (!reset_n)
			dl_wr <= '0;
		else if (ioctl_wr)
			dl_wr <= '1;
		else
			dl_wr <= {1'b0, dl_wr[DL_STRETCH-1:1]};
	end

	// rom images land at their own offset, carts go to banks 14/15
	assign dl_addr = ioctl_rom ? ioctl_addr :
		{cart_bank_hi, ioctl_addr[rom_bank_w:0]};

	assign cpu_we = clk_e & ~cpu_rw & ram_cs;

	// download beats hard reset beats cpu
	always_comb begin
		if (ioctl_download) begin
			ext_ram_addr = {{(ram_addr_w - dl_addr_w){1'b0}}, dl_addr};
			ext_ram_dout = ioctl_data;
			ext_ram_wr   = |dl_wr;
		end else if (hard_reset) begin
			ext_ram_addr = {{(ram_addr_w - cpu_addr_w){1'b0}}, ram_clear_addr}; // wipe the warm start flag
			ext_ram_dout = '0;
			ext_ram_wr   = clk_e;
		end else begin
			ext_ram_addr = {ram_cpu_prefix, sam_addr};
			ext_ram_dout = cpu_dout;
			ext_ram_wr   = cpu_we;
		end
	end

	assign ext_ram_rd = ram_rd_cycle & ~ioctl_download; // ram belongs to the loader

	// cpu read data, at most one select is active
	always_comb begin
		unique case (1'b1)
			ram_cs:  cpu_din = ram_din;
			rom_cs:  cpu_din = rom_src ? rom_din : idle_byte; // empty cart slot
			pia0_cs: cpu_din = pia0_dout;
			pia1_cs: cpu_din = pia1_dout;
			io_cs:   cpu_din = io_dout;
			default: cpu_din = idle_byte;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/coco_mem_map.sv */
// memory map core top: decoder and dram latch feed the external memory mux
`timescale 1ns/1ps
`default_nettype none

module coco_mem_map import coco_mem_pkg::*; #(
	parameter int DL_STRETCH = 8
) (
	input  wire logic                  clk,
	input  wire logic                  reset_n,
	// cpu side
	input  wire logic [cpu_addr_w-1:0] cpu_addr,
	input  wire logic                  cpu_rw,
	input  wire logic                  clk_e,
	input  wire logic [data_w-1:0]     cpu_dout,
	output logic [data_w-1:0]          cpu_din,
	// sam and model straps
	input  wire dev_sel_t              device_select,
	input  wire logic                  ras_n,
	input  wire logic                  cas_n,
	input  wire logic [7:0]            ma_addr,
	input  wire logic                  dragon,
	input  wire logic                  mem64kb,
	input  wire logic                  ddrb2,
	input  wire logic                  pia1_pb2,
	input  wire logic                  disk_cart_enabled,
	input  wire logic                  cart_remove,
	input  wire logic                  hard_reset,
	// rom/cart loader
	input  wire logic                  ioctl_download,
	input  wire logic                  ioctl_cart,
	input  wire logic                  ioctl_rom,
	input  wire logic                  ioctl_wr,
	input  wire logic [dl_addr_w-1:0]  ioctl_addr,
	input  wire logic [data_w-1:0]     ioctl_data,
	// peripheral read bytes
	input  wire logic [data_w-1:0]     pia0_dout,
	input  wire logic [data_w-1:0]     pia1_dout,
	input  wire logic [data_w-1:0]     io_dout,
	// external memories
	input  wire logic [data_w-1:0]     ram_din,
	input  wire logic [data_w-1:0]     rom_din,
	output logic [ram_addr_w-1:0]      ext_ram_addr,
	output logic [data_w-1:0]          ext_ram_dout,
	output logic                       ext_ram_wr,
	output logic                       ext_ram_rd,
	output logic [rom_addr_w-1:0]      ext_rom_addr,
	output logic                       ext_rom_rd,
	output logic [data_w-1:0]          vdg_data
);

	logic                  ram_cs;
	logic                  rom_cs;
	logic                  pia0_cs;
	logic                  pia1_cs;
	logic                  io_cs;
	logic                  rom_src;
	logic [cpu_addr_w-1:0] sam_addr;
	logic                  ram_rd_cycle;

	addr_decode u_addr_decode (
		.clk(clk), .reset_n(reset_n), .cpu_addr(cpu_addr), .cpu_rw(cpu_rw),
		.clk_e(clk_e), .device_select(device_select), .dragon(dragon),
		.mem64kb(mem64kb), .ddrb2(ddrb2), .pia1_pb2(pia1_pb2),
		.disk_cart_enabled(disk_cart_enabled), .cart_remove(cart_remove),
		.ioctl_download(ioctl_download), .ioctl_cart(ioctl_cart),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ram_cs(ram_cs), .rom_cs(rom_cs), .pia0_cs(pia0_cs), .pia1_cs(pia1_cs),
		.io_cs(io_cs), .rom_src(rom_src), .ext_rom_addr(ext_rom_addr),
		.ext_rom_rd(ext_rom_rd)
	);

	dram_addr_latch u_dram_addr_latch (
		.clk(clk), .reset_n(reset_n), .ras_n(ras_n), .cas_n(cas_n),
		.ma_addr(ma_addr), .ram_din(ram_din), .sam_addr(sam_addr),
		.vdg_data(vdg_data), .ram_rd_cycle(ram_rd_cycle)
	);

	ext_mem_mux #(.DL_STRETCH(DL_STRETCH)) u_ext_mem_mux (
		.clk(clk), .reset_n(reset_n), .ioctl_download(ioctl_download),
		.ioctl_rom(ioctl_rom), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_data(ioctl_data), .hard_reset(hard_reset), .clk_e(clk_e),
		.cpu_rw(cpu_rw), .cpu_dout(cpu_dout), .sam_addr(sam_addr),
		.ram_rd_cycle(ram_rd_cycle), .ram_cs(ram_cs), .rom_cs(rom_cs),
		.pia0_cs(pia0_cs), .pia1_cs(pia1_cs), .io_cs(io_cs), .rom_src(rom_src),
		.ram_din(ram_din), .rom_din(rom_din), .pia0_dout(pia0_dout),
		.pia1_dout(pia1_dout), .io_dout(io_dout), .ext_ram_addr(ext_ram_addr),
		.ext_ram_dout(ext_ram_dout), .ext_ram_wr(ext_ram_wr),
		.ext_ram_rd(ext_ram_rd), .cpu_din(cpu_din)
	);

endmodule

`default_nettype wire

/* verif/coco_mem_map_props.sv */
// memory map checker: reference model of the decode, latch and mux rules with bound assertions
`timescale 1ns/1ps
`default_nettype none

module coco_mem_map_props import coco_mem_pkg::*; #(
	parameter int DL_STRETCH = 8
) (
	input wire logic        clk,
	input wire logic        reset_n,
	input wire logic [15:0] cpu_addr,
	input wire logic        cpu_rw,
	input wire logic        clk_e,
	input wire logic [7:0]  cpu_dout,
	input wire logic [7:0]  cpu_din,
	input wire logic [2:0]  device_select,
	input wire logic        ras_n,
	input wire logic        cas_n,
	input wire logic [7:0]  ma_addr,
	input wire logic        dragon,
	input wire logic        mem64kb,
	input wire logic        ddrb2,
	input wire logic        pia1_pb2,
	input wire logic        disk_cart_enabled,
	input wire logic        cart_remove,
	input wire logic        hard_reset,
	input wire logic        ioctl_download,
	input wire logic        ioctl_cart,
	input wire logic        ioctl_rom,
	input wire logic        ioctl_wr,
	input wire logic [16:0] ioctl_addr,
	input wire logic [7:0]  ioctl_data,
	input wire logic [7:0]  pia0_dout,
	input wire logic [7:0]  pia1_dout,
	input wire logic [7:0]  io_dout,
	input wire logic [7:0]  ram_din,
	input wire logic [7:0]  rom_din,
	input wire logic [19:0] ext_ram_addr,
	input wire logic [7:0]  ext_ram_dout,
	input wire logic        ext_ram_wr,
	input wire logic        ext_ram_rd,
	input wire logic [19:0] ext_rom_addr,
	input wire logic        ext_rom_rd,
	input wire logic [7:0]  vdg_data
);

	int          fail_count = 0; // failed assertions so far
	logic        cart;
	int          stretch;
	logic        ras_q;
	logic        cas_q;
	logic        rd_q;
	logic [7:0]  row_byte;
	logic [7:0]  col_byte;
	logic        row_ok;
	logic        col_ok;
	logic [7:0]  vdg_byte;
	logic        vdg_ok;
	logic        d64;
	logic        alt;
	logic        rom_sel;
	logic [3:0]  bank;
	logic [19:0] rom_addr_exp;
	logic [19:0] dl_addr_exp;
	logic [7:0]  din_exp;

	assign d64 = dragon & mem64kb;
	assign alt = d64 & ddrb2 & ~pia1_pb2;
	assign rom_sel = device_select == 3'd1 || device_select == 3'd2 || device_select == 3'd3;

	// bank table per model
	always_comb begin
		case (device_select)
			3'd1:    bank = d64 ? (alt ? 4'd7 : 4'd5) : (dragon ? 4'd3 : 4'd1);
			3'd2:    bank = d64 ? (alt ? 4'd8 : 4'd6) : (dragon ? 4'd4 : 4'd0);
			3'd3:    bank = cart ? (cpu_addr[13] ? 4'd15 : 4'd14) : (dragon ? 4'd9 : 4'd2);
			default: bank = 4'd0;
		endcase
		rom_addr_exp = {3'b000, bank, cpu_addr[12:0]};
		dl_addr_exp = ioctl_rom ? {3'b000, ioctl_addr} : {6'b000111, ioctl_addr[13:0]};
	end

	// expected read byte
	always_comb begin
		case (device_select)
			3'd0: din_exp = ram_din;
			3'd1, 3'd2: din_exp = cpu_rw ? rom_din : 8'hff;
			3'd3: din_exp = (cpu_rw && (cart || disk_cart_enabled)) ? rom_din : 8'hff;
			3'd4: din_exp = (d64 && cpu_addr[2]) ? 8'hff : pia0_dout; // acia slot
			3'd5: din_exp = pia1_dout;
			3'd6: din_exp = io_dout;
			default: din_exp = 8'hff;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			cart    <= 1'b0;
			stretch <= 0;
			ras_q   <= 1'b1;
			cas_q   <= 1'b1;
			rd_q    <= 1'b0;
			row_ok  <= 1'b0;
			col_ok  <= 1'b0;
			vdg_ok  <= 1'b0;
		end else begin
			if (ioctl_cart && ioctl_download && !ioctl_wr)
				cart <= ioctl_addr > 17'h100;
			else if (cart_remove)
				cart <= 1'b0;
			if (ioctl_wr)
				stretch <= DL_STRETCH;
			else if (stretch > 0)
				stretch <= stretch - 1;
			ras_q <= ras_n;
			cas_q <= cas_n;
			rd_q  <= ~cas_n;
			if (!ras_n && ras_q) begin
				row_byte <= ma_addr;
				row_ok   <= 1'b1;
			end
			if (!cas_n && cas_q) begin
				col_byte <= ma_addr;
				col_ok   <= 1'b1;
			end
			if (ras_n && !ras_q) begin
				vdg_byte <= ram_din;
				vdg_ok   <= 1'b1;
			end
		end
	end

	a_rom_addr: assert property (@(posedge clk) disable iff (!reset_n)
		rom_sel |-> ext_rom_addr == rom_addr_exp)
		else begin
			fail_count++;
			$error("MISMATCH ext_rom_addr got %h expected %h", ext_rom_addr, rom_addr_exp);
		end

	a_rom_rd: assert property (@(posedge clk) disable iff (!reset_n)
		ext_rom_rd == (clk_e & rom_sel))
		else begin
			fail_count++;
			$error("MISMATCH ext_rom_rd got %h expected %h", ext_rom_rd, clk_e & rom_sel);
		end

	a_cpu_din: assert property (@(posedge clk) disable iff (!reset_n)
		cpu_din == din_exp)
		else begin
			fail_count++;
			$error("MISMATCH cpu_din got %h expected %h", cpu_din, din_exp);
		end

	a_dl_addr: assert property (@(posedge clk) disable iff (!reset_n)
		ioctl_download |-> ext_ram_addr == dl_addr_exp && ext_ram_dout == ioctl_data)
		else begin
			fail_count++;
			$error("MISMATCH ext_ram_addr/ext_ram_dout got %h/%h expected %h/%h",
				ext_ram_addr, ext_ram_dout, dl_addr_exp, ioctl_data);
		end

	a_dl_wr: assert property (@(posedge clk) disable iff (!reset_n)
		ioctl_download |-> ext_ram_wr == (stretch != 0))
		else begin
			fail_count++;
			$error("MISMATCH ext_ram_wr got %h expected %h", ext_ram_wr, stretch != 0);
		end

	a_clear: assert property (@(posedge clk) disable iff (!reset_n)
		hard_reset && !ioctl_download |->
			ext_ram_addr == 20'h00071 && ext_ram_dout == 8'h00 && ext_ram_wr == clk_e)
		else begin
			fail_count++;
			$error("MISMATCH ext_ram_addr/ext_ram_dout/ext_ram_wr got %h/%h/%h expected %h/%h/%h",
				ext_ram_addr, ext_ram_dout, ext_ram_wr, 20'h00071, 8'h00, clk_e);
		end

	a_cpu_ram: assert property (@(posedge clk) disable iff (!reset_n)
		!hard_reset && !ioctl_download && row_ok && col_ok |->
			ext_ram_addr == {4'b1000, col_byte, row_byte} && ext_ram_dout == cpu_dout
			&& ext_ram_wr == (clk_e && !cpu_rw && device_select == 3'd0))
		else begin
			fail_count++;
			$error("MISMATCH ext_ram_addr/ext_ram_dout/ext_ram_wr got %h/%h/%h expected %h/%h/%h",
				ext_ram_addr, ext_ram_dout, ext_ram_wr, {4'b1000, col_byte, row_byte},
				cpu_dout, clk_e && !cpu_rw && device_select == 3'd0);
		end

	a_ram_rd: assert property (@(posedge clk) disable iff (!reset_n)
		ext_ram_rd == (rd_q & ~ioctl_download))
		else begin
			fail_count++;
			$error("MISMATCH ext_ram_rd got %h expected %h", ext_ram_rd, rd_q & ~ioctl_download);
		end

	a_vdg: assert property (@(posedge clk) disable iff (!reset_n)
		vdg_ok |-> vdg_data == vdg_byte)
		else begin
			fail_count++;
			$error("MISMATCH vdg_data got %h expected %h", vdg_data, vdg_byte);
		end

endmodule

`default_nettype wire

/* verif/tb_coco_mem_map.sv */
// memory map testbench: random bus traffic, downloads and hard reset against bound assertions
`timescale 1ns/1ps
`default_nettype none

module tb_coco_mem_map import coco_mem_pkg::*;;

	localparam int DL_STRETCH = 8;
	localparam int n_cycles   = 1400; // upper bound on all phases together

	logic        clk = 1'b0;
	logic        reset_n;
	logic [15:0] cpu_addr;
	logic        cpu_rw;
	logic        clk_e;
	logic [7:0]  cpu_dout;
	logic [7:0]  cpu_din;
	dev_sel_t    device_select;
	logic        ras_n;
	logic        cas_n;
	logic [7:0]  ma_addr;
	logic        dragon;
	logic        mem64kb;
	logic        ddrb2;
	logic        pia1_pb2;
	logic        disk_cart_enabled;
	logic        cart_remove;
	logic        hard_reset;
	logic        ioctl_download;
	logic        ioctl_cart;
	logic        ioctl_rom;
	logic        ioctl_wr;
	logic [16:0] ioctl_addr;
	logic [7:0]  ioctl_data;
	logic [7:0]  pia0_dout;
	logic [7:0]  pia1_dout;
	logic [7:0]  io_dout;
	logic [7:0]  ram_din;
	logic [7:0]  rom_din;
	logic [19:0] ext_ram_addr;
	logic [7:0]  ext_ram_dout;
	logic        ext_ram_wr;
	logic        ext_ram_rd;
	logic [19:0] ext_rom_addr;
	logic        ext_rom_rd;
	logic [7:0]  vdg_data;
	logic [15:0] lfsr = 16'd19876;
	int          fails;

	coco_mem_map #(.DL_STRETCH(DL_STRETCH)) u_coco_mem_map (.*);

	bind coco_mem_map coco_mem_map_props #(.DL_STRETCH(DL_STRETCH)) u_props (.*);

	always #20 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// next falling edge, fresh bus values
	task automatic next_cycle();
		@(negedge clk);
		cpu_addr          = rand_bits(16);
		cpu_rw            = rand_bits(1);
		clk_e             = rand_bits(1);
		cpu_dout          = rand_bits(8);
		device_select     = dev_sel_t'(rand_bits(3));
		ras_n             = rand_bits(1);
		cas_n             = rand_bits(1);
		ma_addr           = rand_bits(8);
		dragon            = rand_bits(1);
		mem64kb           = rand_bits(1);
		ddrb2             = rand_bits(1);
		pia1_pb2          = rand_bits(1);
		disk_cart_enabled = rand_bits(1);
		ioctl_data        = rand_bits(8);
		pia0_dout         = rand_bits(8);
		pia1_dout         = rand_bits(8);
		io_dout           = rand_bits(8);
		ram_din           = rand_bits(8);
		rom_din           = rand_bits(8);
	endtask

	task automatic run_random(input int n);
		repeat (n) next_cycle();
	endtask

	// loader session: a burst of writes, then the strobe stretch runs out
	task automatic download(input logic is_cart, input logic [16:0] base, input int n_bytes);
		for (int i = 0; i < n_bytes; i++) begin
			next_cycle();
			ioctl_download = 1'b1;
			ioctl_cart     = is_cart;
			ioctl_rom      = ~is_cart;
			ioctl_wr       = 1'b1;
			ioctl_addr     = base + 17'(i);
			repeat (rand_bits(2)) begin
				next_cycle();
				ioctl_wr = 1'b0;
			end
		end
		repeat (DL_STRETCH + 4) begin
			next_cycle();
			ioctl_wr = 1'b0;
		end
		next_cycle();
		ioctl_download = 1'b0;
		ioctl_cart     = 1'b0;
		ioctl_rom      = 1'b0;
	endtask

	initial begin
		#(n_cycles * 40 + 4000);
		$display("watchdog: run did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		reset_n        = 1'b0;
		cart_remove    = 1'b0;
		hard_reset     = 1'b0;
		ioctl_download = 1'b0;
		ioctl_cart     = 1'b0;
		ioctl_rom      = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		cpu_addr       = '0;
		cpu_rw         = 1'b1;
		clk_e          = 1'b0;
		cpu_dout       = '0;
		device_select  = dev_ram;
		ras_n          = 1'b1;
		cas_n          = 1'b1;
		ma_addr        = '0;
		dragon         = 1'b0;
		mem64kb        = 1'b0;
		ddrb2          = 1'b0;
		pia1_pb2       = 1'b0;
		disk_cart_enabled = 1'b0;
		ioctl_data     = '0;
		pia0_dout      = '0;
		pia1_dout      = '0;
		io_dout        = '0;
		ram_din        = '0;
		rom_din        = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		run_random(300);              // no cart yet
		download(1'b1, 17'h1f00, 12); // big cart, ends above 0x100
		run_random(250);
		next_cycle();
		cart_remove = 1'b1;
		next_cycle();
		cart_remove = 0;
		run_random(150);
		download(1'b0, 17'h0a000, 10); // rom image
		download(1'b1, 17'h1f00, 4);   // cart loaded again
		download(1'b1, 17'h0040, 6);   // tiny cart unloads it
		run_random(80);
		next_cycle();
		hard_reset = 1'b1;
		run_random(60);
		hard_reset = 1'b0;
		run_random(40);

		@(posedge clk);
		#1;
		fails = u_coco_mem_map.u_props.fail_count;
		$display("run complete: %0d assertion failures", fails);
		if (fails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
rtl/coco_mem_pkg.sv
rtl/addr_decode.sv
rtl/dram_addr_latch.sv
rtl/ext_mem_mux.sv
rtl/coco_mem_map.sv
verif/coco_mem_map_props.sv
verif/tb_coco_mem_map.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory map testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f project.f --top-module tb_coco_mem_map -o tb_coco_mem_map
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/tb_coco_mem_map +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
	exit 0
else
	echo "pass message not found in $LOG"
	exit 1
fi
